/* analog_io_top.f */
src/analog_io_pkg.sv
src/adc_frontend.sv
src/dac_channel.sv
src/dac_interleaver.sv
src/analog_io_top.sv
tests/analog_io_tb.sv

/* Makefile */
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
TOP        := analog_io_tb
RTL_TOP    := analog_io_top
FILELIST   := analog_io_top.f
OBJ_DIR    := obj_dir
PASS_MSG   := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* tests/analog_io_tb.sv */
////////////////////
// Testbench for the analog data path: random ADC words and sample sets
// from a fixed seed, a credit-limited source, all checked against a local model
////////////////////

`timescale 1ns/1ns

module analog_io_tb;

  import analog_io_pkg::*;

  localparam int NUM_CH        = DEF_NUM_CH;
  localparam int FIFO_DEPTH    = DEF_FIFO_DEPTH;
  localparam int SEL_W         = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;
  localparam int DRAIN_TIMEOUT = 200;  // Cycles

  logic                adc_clk;
  logic                reset_i;
  raw_t                adc_dat_i [NUM_CH];
  logic                digital_loop_i;
  logic                gen_valid_i;
  sample_t             asg_dat_i [NUM_CH];
  sample_t             pid_dat_i [NUM_CH];
  logic                gen_credit_o;
  sample_t             adc_dat_o [NUM_CH];
  logic [SAMPLE_W-1:0] dac_dat_o;
  logic [SEL_W-1:0]    dac_sel_o;
  logic                dac_wrt_o;

  sample_t exp_q [$];           // Expected DAC samples in send order
  sample_t last_sent [NUM_CH];  // Loopback reference
  raw_t    raw_d1 [NUM_CH];     // Driven on the last tick
  raw_t    raw_d2 [NUM_CH];     // Two ticks back, now at adc_dat_o
  int      adc_hist;
  int      credits;             // Held by the source
  int      sets_sent;
  int      wr_cnt;
  int      seed_ret;

  analog_io_top u_analog_io_top (.*);

  initial
  begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;
  end

  // Reference sums and converter code rules
  function automatic sample_t sat_sum(input sample_t a, input sample_t b);
    int s;
    s = int'(a) + int'(b);
    if (s > 8191)
      s = 8191;
    else if (s < -8192)
      s = -8192;
    return sample_t'(s);
  endfunction

  function automatic logic [SAMPLE_W-1:0] offset_code(input sample_t s);
    return s ^ 14'h1fff;  // MSB kept, rest inverted
  endfunction

  function automatic sample_t twos_from_raw(input raw_t r);
    return sample_t'(r[15:2] ^ 14'h1fff);  // Low two bits ignored
  endfunction

  function automatic sample_t rand_sample();
    int pick;
    pick = $urandom_range(0, 7);
    if (pick == 0)
      return sample_t'(8191);  // Full scale, pairs force clamping
    if (pick == 1)
      return sample_t'(-8192);
    return sample_t'($urandom);
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] want, input string what);
    if (got !== want)
    begin
      $display("[FAIL] %0t ns: %s, got %0h expected %0h", $time, what, got, want);
      $display("Simulation failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("%0t ns: %s", $time, why);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  ////////////////////
  // One clock step: sample, model, drive
  ////////////////////

  task automatic tick(input logic want_valid);
    sample_t exp_smp;
    sample_t a;
    sample_t p;
    raw_t    r;
    int      ch;
    @(posedge adc_clk);
    if (dac_wrt_o)
    begin
      if (exp_q.size() == 0)
        abort_run("DAC write seen with no sample set outstanding");
      else
      begin
        exp_smp = exp_q.pop_front();
        ch      = wr_cnt % NUM_CH;
        check(32'(dac_sel_o), ch, "dac_sel_o order");
        check(32'(dac_dat_o), 32'(offset_code(exp_smp)), "dac_dat_o word");
        last_sent[ch] = exp_smp;
        wr_cnt++;
        if (ch == NUM_CH - 1 && digital_loop_i)  // Set complete, loopback updated
          for (int c = 0; c < NUM_CH; c++)
            check(32'(adc_dat_o[c]), 32'(last_sent[c]), "loopback after set");
      end
    end
    if (adc_hist == 2 && !digital_loop_i)
      for (int c = 0; c < NUM_CH; c++)
        check(32'(adc_dat_o[c]), 32'(twos_from_raw(raw_d2[c])), "ADC conversion");
    if (gen_credit_o)
      credits++;
    check(32'(credits >= 0 && credits <= FIFO_DEPTH), 32'd1, "held credits in range");
    for (int c = 0; c < NUM_CH; c++)
    begin
      r = raw_t'($urandom);
      adc_dat_i[c] <= r;
      raw_d2[c] = raw_d1[c];
      raw_d1[c] = r;
    end
    if (adc_hist < 2)
      adc_hist++;
    if (want_valid && credits > 0)
    begin
      credits--;
      sets_sent++;
      for (int c = 0; c < NUM_CH; c++)
      begin
        a = rand_sample();
        p = rand_sample();
        asg_dat_i[c] <= a;
        pid_dat_i[c] <= p;
        exp_q.push_back(sat_sum(a, p));
      end
      gen_valid_i <= 1'b1;
    end
    else
      gen_valid_i <= 1'b0;
  endtask

  // Random bursts, then drain until every credit is back
  task automatic run_phase(input logic loop_on, input int cycles);
    int   left;
    int   waited;
    logic on;
    left   = 0;
    waited = 0;
    on     = 1'b0;
    digital_loop_i <= loop_on;
    tick(1'b0);
    if (loop_on)  // Last set so far, or 0 before any
      for (int c = 0; c < NUM_CH; c++)
        check(32'(adc_dat_o[c]), 32'(last_sent[c]), "loopback at phase start");
    for (int i = 0; i < cycles; i++)
    begin
      if (left == 0)
      begin
        on   = !on;
        left = $urandom_range(1, 8);  // Burst or gap length
      end
      tick(on);
      left--;
    end
    while (credits != FIFO_DEPTH)
    begin
      if (waited >= DRAIN_TIMEOUT)
        abort_run("timed out waiting for all credits to return");
      else
      begin
        tick(1'b0);
        waited++;
      end
    end
    check(wr_cnt, NUM_CH * sets_sent, "DAC write count");
    check(exp_q.size(), 0, "sets left undelivered");
  endtask

  initial
  begin
    reset_i        = 1'b1;
    digital_loop_i = 1'b0;
    gen_valid_i    = 1'b0;
    for (int c = 0; c < NUM_CH; c++)
    begin
      adc_dat_i[c] = '0;
      asg_dat_i[c] = '0;
      pid_dat_i[c] = '0;
      last_sent[c] = '0;
      raw_d1[c]    = '0;
      raw_d2[c]    = '0;
    end
    adc_hist  = 0;
    credits   = FIFO_DEPTH;  // Full budget after reset
    sets_sent = 0;
    wr_cnt    = 0;
    seed_ret  = $urandom(32'hb56a_8469);

    repeat (3) @(posedge adc_clk);
    reset_i <= 1'b0;
    @(posedge adc_clk);  // Outputs still show reset values here
    check(32'(dac_wrt_o), 32'd0, "dac_wrt_o after reset");
    check(32'(gen_credit_o), 32'd0, "gen_credit_o after reset");
    check(32'(dac_sel_o), 32'd0, "dac_sel_o after reset");
    check(32'(dac_dat_o), 32'(offset_code('0)), "dac_dat_o after reset");

    repeat (100) tick(1'b0);  // ADC conversion only
    run_phase(1'b1, 200);     // Loopback on
    run_phase(1'b0, 300);     // Saturation and credits, ADC checked alongside

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* src/analog_io_top.sv */
////////////////////
// Analog data path top: ADC front end, per channel DAC queues, DAC interleaver
// Everything on adc_clk; sample source uses the credit handshake
////////////////////

`timescale 1ns/1ns

module analog_io_top #(
  parameter  int NUM_CH     = analog_io_pkg::DEF_NUM_CH,
  parameter  int FIFO_DEPTH = analog_io_pkg::DEF_FIFO_DEPTH,
  localparam int SEL_W      = (NUM_CH > 1) ? $clog2(NUM_CH) : 1
)(
  input  logic                               adc_clk,
  input  logic                               reset_i,
  // ADC
  input  analog_io_pkg::raw_t                adc_dat_i [NUM_CH],
  input  logic                               digital_loop_i,
  // Sample source
  input  logic                               gen_valid_i,  // Spends one credit
  input  analog_io_pkg::sample_t             asg_dat_i [NUM_CH],
  input  analog_io_pkg::sample_t             pid_dat_i [NUM_CH],
  output logic                               gen_credit_o,  // Returns one credit
  output analog_io_pkg::sample_t             adc_dat_o [NUM_CH],
  // DAC bus
  output logic [analog_io_pkg::SAMPLE_W-1:0] dac_dat_o,
  output logic [SEL_W-1:0]                   dac_sel_o,
  output logic                               dac_wrt_o
);

  import analog_io_pkg::*;

  sample_t loop_dat [NUM_CH];  // Interleaver back to front end
  sample_t ch_dat   [NUM_CH];  // Queue heads
  logic    ch_avail [NUM_CH];
  logic    pop;                // Common to all queues

  ////////////////////
  // ADC path
  ////////////////////

  adc_frontend #(.NUM_CH (NUM_CH)) u_adc_frontend (
    .adc_clk        (adc_clk       ),
    .reset_i        (reset_i       ),
    .adc_dat_i      (adc_dat_i     ),
    .digital_loop_i (digital_loop_i),
    .loop_dat_i     (loop_dat      ),
    .adc_dat_o      (adc_dat_o     )
  );

  ////////////////////
  // DAC path
  ////////////////////

  // One queue per output channel, all pushed together
  for (genvar c = 0; c < NUM_CH; c++)
  begin : g_ch
    dac_channel #(.FIFO_DEPTH (FIFO_DEPTH)) u_dac_channel (
      .adc_clk    (adc_clk     ),
      .reset_i    (reset_i     ),
      .push_i     (gen_valid_i ),
      .asg_dat_i  (asg_dat_i[c]),
      .pid_dat_i  (pid_dat_i[c]),
      .pop_i      (pop         ),
      .ch_dat_o   (ch_dat[c]   ),
      .ch_avail_o (ch_avail[c] )
    );
  end

  dac_interleaver #(
    .NUM_CH     (NUM_CH    ),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_dac_interleaver (
    .adc_clk      (adc_clk     ),
    .reset_i      (reset_i     ),
    .ch_dat_i     (ch_dat      ),
    .ch_avail_i   (ch_avail    ),
    .pop_o        (pop         ),
    .loop_dat_o   (loop_dat    ),
    .gen_credit_o (gen_credit_o),
    .dac_dat_o    (dac_dat_o   ),
    .dac_sel_o    (dac_sel_o   ),
    .dac_wrt_o    (dac_wrt_o   )
  );

endmodule

/* src/dac_interleaver.sv */
////////////////////
// Drains the channel queues onto the shared DAC bus, one word per cycle
// Returns one credit per finished set and keeps the loopback values
////////////////////

`timescale 1ns/1ns

module dac_interleaver #(
  parameter  int NUM_CH     = analog_io_pkg::DEF_NUM_CH,
  parameter  int FIFO_DEPTH = analog_io_pkg::DEF_FIFO_DEPTH,
  localparam int SEL_W      = (NUM_CH > 1) ? $clog2(NUM_CH) : 1
)(
  input  logic                                adc_clk,
  input  logic                                reset_i,
  input  analog_io_pkg::sample_t              ch_dat_i   [NUM_CH],  // Queue heads
  input  logic                                ch_avail_i [NUM_CH],
  output logic                                pop_o,      // Shared by all queues
  output analog_io_pkg::sample_t              loop_dat_o [NUM_CH],
  output logic                                gen_credit_o,
  output logic [analog_io_pkg::SAMPLE_W-1:0]  dac_dat_o,  // Offset binary
  output logic [SEL_W-1:0]                    dac_sel_o,
  output logic                                dac_wrt_o
);

  import analog_io_pkg::*;

  logic              all_avail;
  logic [SEL_W-1:0]  idx;       // Channel being sent
  logic              last_ch;

  // Queues move in lockstep, still wait for every one
  always_comb
  begin
    all_avail = 1'b1;
    for (int c = 0; c < NUM_CH; c++)
      all_avail = all_avail & ch_avail_i[c];
  end

  assign last_ch = (idx == SEL_W'(NUM_CH - 1));
  assign pop_o   = all_avail && last_ch;  // Pop on the last word's edge

  ////////////////////
  // DAC bus
  ////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      idx       <= '0;
      dac_wrt_o <= 1'b0;
      dac_sel_o <= '0;
      dac_dat_o <= to_offset('0);
    end
    else
    begin
      dac_wrt_o <= all_avail;
      if (all_avail)
      begin
        dac_sel_o <= idx;
        dac_dat_o <= to_offset(ch_dat_i[idx]);
        idx       <= last_ch ? '0 : idx + 1'b1;  // Next set may follow at once
      end
    end
  end

  ////////////////////
  // Loopback and credits
  ////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      gen_credit_o <= 1'b0;
      for (int c = 0; c < NUM_CH; c++)
        loop_dat_o[c] <= '0;
    end
    else
    begin
      gen_credit_o <= pop_o;  // One cycle after the pop
      if (pop_o)
      begin
        for (int c = 0; c < NUM_CH; c++)
          loop_dat_o[c] <= ch_dat_i[c];  // Last values sent
      end
    end
  end

  // Words of one set go out on consecutive indices
  assert property (@(posedge adc_clk) disable iff (reset_i)
    (dac_wrt_o && (dac_sel_o != SEL_W'(NUM_CH - 1)))
      |=> (dac_wrt_o && (dac_sel_o == $past(dac_sel_o) + 1'b1)))
    else $error("DAC channel select skipped within a set");

endmodule

/* src/dac_channel.sv */
////////////////////
// One DAC channel: generator plus controller sum, saturated and queued
// Pushed by the sample source, popped by the interleaver
////////////////////

`timescale 1ns/1ns

module dac_channel #(
  parameter int FIFO_DEPTH = analog_io_pkg::DEF_FIFO_DEPTH
)(
  input  logic                   adc_clk,
  input  logic                   reset_i,
  input  logic                   push_i,     // New sample set
  input  analog_io_pkg::sample_t asg_dat_i,  // Generator sample
  input  analog_io_pkg::sample_t pid_dat_i,  // Controller sample
  input  logic                   pop_i,      // Set has left on the DAC bus
  output analog_io_pkg::sample_t ch_dat_o,   // Queue head
  output logic                   ch_avail_o  // Queue not empty
);

  import analog_io_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  sum_t             sum;
  sample_t          sum_sat;
  sample_t          mem [FIFO_DEPTH];  // Queue storage
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;  // Occupancy

  // Pointer step with wrap, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(FIFO_DEPTH - 1))
      return '0;
    return p + 1'b1;
  endfunction

  ////////////////////
  // Summation
  ////////////////////

  assign sum     = sum_t'(asg_dat_i) + sum_t'(pid_dat_i);  // Sign extended
  assign sum_sat = saturate(sum);

  ////////////////////
  // Circular queue
  ////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (push_i)
      mem[wr_ptr] <= sum_sat;
  end

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr <= ptr_inc(wr_ptr);
      if (pop_i)
        rd_ptr <= ptr_inc(rd_ptr);
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  assign ch_dat_o   = mem[rd_ptr];
  assign ch_avail_o = (count != '0);

  // Credits must keep the source off a full queue
  assert property (@(posedge adc_clk) disable iff (reset_i)
    push_i |-> (count < CNT_W'(FIFO_DEPTH)))
    else $error("push to full channel queue");

  // Interleaver only pops a queue it saw holding data
  assert property (@(posedge adc_clk) disable iff (reset_i)
    pop_i |-> (count != '0))
    else $error("pop from empty channel queue");

endmodule

/* src/adc_frontend.sv */
////////////////////
// ADC capture: registers raw words, converts to two's complement
// Digital loopback swaps in the last DAC sample per channel
////////////////////

`timescale 1ns/1ns

module adc_frontend #(
  parameter int NUM_CH = analog_io_pkg::DEF_NUM_CH
)(
  input  logic                   adc_clk,
  input  logic                   reset_i,
  input  analog_io_pkg::raw_t    adc_dat_i  [NUM_CH],  // Raw converter words
  input  logic                   digital_loop_i,
  input  analog_io_pkg::sample_t loop_dat_i [NUM_CH],  // Last sample sent to DAC
  output analog_io_pkg::sample_t adc_dat_o  [NUM_CH]
);

  import analog_io_pkg::*;

  ////////////////////
  // Capture registers
  ////////////////////

  // Stand-ins for the IO block registers
  logic [SAMPLE_W-1:0] adc_raw_q [NUM_CH];

  // Top 14 bits only, low two are reserved on a 16 bit part
  always_ff @(posedge adc_clk)
  begin
    for (int c = 0; c < NUM_CH; c++)
    begin
      if (reset_i)
        adc_raw_q[c] <= to_offset('0);  // Code that reads back as zero
      else
        adc_raw_q[c] <= adc_dat_i[c][ADC_RAW_W-1:ADC_RAW_W-SAMPLE_W];
    end
  end

  ////////////////////
  // Conversion and loopback
  ////////////////////

  // Loopback path is purely combinational
  always_comb
  begin
    for (int c = 0; c < NUM_CH; c++)
    begin
      if (digital_loop_i)
        adc_dat_o[c] = loop_dat_i[c];  // DAC value fed back
      else
        adc_dat_o[c] = to_twos(adc_raw_q[c]);  // Negative slope fix
    end
  end

endmodule

/* src/analog_io_pkg.sv */
////////////////////
// Shared widths, sample types and converter code rules for the analog path
// Imported by every RTL block; defaults feed the top level parameters
////////////////////

package analog_io_pkg;

  localparam int SAMPLE_W  = 14;  // Converter resolution
  localparam int ADC_RAW_W = 16;  // ADC port, two reserved low bits

  localparam int DEF_NUM_CH     = 2;
  localparam int DEF_FIFO_DEPTH = 4;  // Sets per channel queue

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic        [ADC_RAW_W-1:0] raw_t;
  typedef logic signed [SAMPLE_W:0]   sum_t;  // One guard bit for the adder

  // Negative slope offset binary to two's complement
  function automatic sample_t to_twos(input logic [SAMPLE_W-1:0] code);
    return sample_t'({code[SAMPLE_W-1], ~code[SAMPLE_W-2:0]});
  endfunction

  // Same bit rule, DAC direction
  function automatic logic [SAMPLE_W-1:0] to_offset(input sample_t smp);
    return {smp[SAMPLE_W-1], ~smp[SAMPLE_W-2:0]};
  endfunction

  // Clamp to -8192..8191 when the two top bits disagree
  function automatic sample_t saturate(input sum_t s);
    if (s[SAMPLE_W] != s[SAMPLE_W-1])
      return sample_t'({s[SAMPLE_W], {(SAMPLE_W-1){~s[SAMPLE_W]}}});
    return s[SAMPLE_W-1:0];
  endfunction

endpackage
